//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cdma_status
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard tests/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
+incdir+tests
rtl/cdma_status_pkg.sv
rtl/cdma_status_decode.sv
rtl/cbuf_accounting.sv
rtl/cdma_done_ctrl.sv
rtl/cdma_update_delay.sv
rtl/cdma_status.sv
tests/tb_cdma_status.sv

//--- rtl/cbuf_accounting.sv
`timescale 1ns/10ps

module cbuf_accounting (
  input  logic                                nvdla_core_clk,
  input  logic                                rst,
  input  logic                                reg2dp_op_en,
  input  logic [cdma_status_pkg::BANK_W-1:0]  reg2dp_data_bank,
  input  cdma_status_pkg::buf_update_t        dma_add,
  input  cdma_status_pkg::buf_update_t        sc2cdma_dat,
  input  logic                                dat_pend,
  input  logic                                sc2cdma_dat_pending_req,
  output logic                                cdma2sc_dat_pending_ack,
  output cdma_status_pkg::slice_cnt_t         status2dma_valid_slices,
  output cdma_status_pkg::entry_cnt_t         status2dma_free_entries,
  output cdma_status_pkg::entry_cnt_t         status2dma_wr_idx
);

  import cdma_status_pkg::*;

  bank_num_t          real_bank;
  entry_cnt_t         valid_entries;
  logic               pending_req;
  logic               pending_clr;
  logic               update_all;
  entry_cnt_t         entries_sub;
  slice_cnt_t         slices_sub;
  entry_cnt_t         valid_entries_nxt;
  slice_cnt_t         valid_slices_nxt;
  entry_cnt_t         free_entries_nxt;
  entry_cnt_t         bank_cap;
  logic [ENTRY_W:0]   wr_idx_inc;
  logic [ENTRY_W:0]   wr_idx_wrap;
  logic               wr_idx_overflow;
  entry_cnt_t         wr_idx_nxt;

  ////////////////////////////////////////////////////////////
  // counter next values
  ////////////////////////////////////////////////////////////

  // both sides of the pending exchange high clears everything
  assign pending_clr = cdma2sc_dat_pending_ack & pending_req;
  assign update_all  = dma_add.updt | sc2cdma_dat.updt | pending_clr;

  // sequencer releases only count on its strobe
  assign entries_sub = sc2cdma_dat.updt ? sc2cdma_dat.entries : '0;
  assign slices_sub  = sc2cdma_dat.updt ? sc2cdma_dat.slices : '0;

  assign valid_entries_nxt = pending_clr ? '0 :
                             valid_entries + dma_add.entries - entries_sub;
  assign valid_slices_nxt  = pending_clr ? '0 :
                             status2dma_valid_slices + dma_add.slices - slices_sub;

  // capacity of the enabled banks at 512 entries each
  assign bank_cap         = {real_bank, {BANK_DEPTH_BITS{1'b0}}};
  assign free_entries_nxt = bank_cap - valid_entries_nxt;

  ////////////////////////////////////////////////////////////
  // write index
  ////////////////////////////////////////////////////////////

  // one extra bit so the sum can pass the last bank
  assign wr_idx_inc      = {1'b0, status2dma_wr_idx} + {1'b0, dma_add.entries};
  assign wr_idx_wrap     = wr_idx_inc - {1'b0, bank_cap};
  assign wr_idx_overflow = (wr_idx_inc >= {1'b0, bank_cap});

  // releases leave the index alone, only fetch updates move it
  assign wr_idx_nxt = pending_clr      ? '0 :
                      !dma_add.updt    ? status2dma_wr_idx :
                      wr_idx_overflow  ? wr_idx_wrap[ENTRY_W-1:0] :
                                         wr_idx_inc[ENTRY_W-1:0];

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      real_bank               <= '0;
      valid_entries           <= '0;
      status2dma_valid_slices <= '0;
      status2dma_free_entries <= '0;
      status2dma_wr_idx       <= '0;
      cdma2sc_dat_pending_ack <= 1'b0;
      pending_req             <= 1'b0;
    end else begin
      // bank count follows the register field while the layer runs
      if (reg2dp_op_en) begin
        real_bank <= bank_num_t'(reg2dp_data_bank) + 1'b1;
      end
      if (update_all) begin
        valid_entries           <= valid_entries_nxt;
        status2dma_valid_slices <= valid_slices_nxt;
        status2dma_wr_idx       <= wr_idx_nxt;
      end
      // tracks both the counter and a change of bank count
      status2dma_free_entries <= free_entries_nxt;
      cdma2sc_dat_pending_ack <= reg2dp_op_en & dat_pend;
      pending_req             <= sc2cdma_dat_pending_req;
    end
  end

endmodule

//--- rtl/cdma_done_ctrl.sv
`timescale 1ns/10ps

module cdma_done_ctrl (
  input  logic                             nvdla_core_clk,
  input  logic                             rst,
  input  logic                             reg2dp_op_en,
  input  logic                             dp2reg_consumer,
  input  logic                             wt_done,
  input  logic                             dat_done,
  output logic                             dp2reg_done,
  output cdma_status_pkg::done_intr_t      cdma_wt2glb_done_intr_pd,
  output cdma_status_pkg::done_intr_t      cdma_dat2glb_done_intr_pd
);

  import cdma_status_pkg::*;

  logic wt_done_d1;
  logic dat_done_d1;
  logic wt_rise;
  logic dat_rise;
  logic layer_switch_nxt;

  // route a done edge to the bit owned by the current consumer
  function automatic done_intr_t steer(input logic rise, input logic consumer);
    done_intr_t intr;
    intr[0] = rise & ~consumer;
    intr[1] = rise & consumer;
    return intr;
  endfunction

  ////////////////////////////////////////////////////////////
  // layer switch
  ////////////////////////////////////////////////////////////

  // held levels make this toggle every cycle
  assign layer_switch_nxt = reg2dp_op_en & ~dp2reg_done & wt_done & dat_done;

  // rising edges of the done levels, only while enabled
  assign wt_rise  = reg2dp_op_en & wt_done & ~wt_done_d1;
  assign dat_rise = reg2dp_op_en & dat_done & ~dat_done_d1;

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      dp2reg_done               <= 1'b0;
      wt_done_d1                <= 1'b0;
      dat_done_d1               <= 1'b0;
      cdma_wt2glb_done_intr_pd  <= '0;
      cdma_dat2glb_done_intr_pd <= '0;
    end else begin
      dp2reg_done               <= layer_switch_nxt;
      // delayed copies are gated so a new layer sees a fresh edge
      wt_done_d1                <= reg2dp_op_en & wt_done;
      dat_done_d1               <= reg2dp_op_en & dat_done;
      cdma_wt2glb_done_intr_pd  <= steer(wt_rise, dp2reg_consumer);
      cdma_dat2glb_done_intr_pd <= steer(dat_rise, dp2reg_consumer);
    end
  end

endmodule

//--- rtl/cdma_status.sv
`timescale 1ns/10ps

module cdma_status (
  input  logic                                nvdla_core_clk,
  input  logic                                rst,
  input  cdma_status_pkg::buf_update_t        dc2status_dat,
  input  cdma_status_pkg::buf_update_t        img2status_dat,
  input  cdma_status_pkg::status_state_e      dc2status_state,
  input  cdma_status_pkg::status_state_e      img2status_state,
  input  cdma_status_pkg::status_state_e      wt2status_state,
  input  cdma_status_pkg::buf_update_t        sc2cdma_dat,
  input  logic                                sc2cdma_dat_pending_req,
  input  logic                                reg2dp_op_en,
  input  logic                                dp2reg_consumer,
  input  logic [cdma_status_pkg::BANK_W-1:0]  reg2dp_data_bank,
  output cdma_status_pkg::buf_update_t        cdma2sc_dat,
  output logic                                cdma2sc_dat_pending_ack,
  output cdma_status_pkg::slice_cnt_t         status2dma_valid_slices,
  output cdma_status_pkg::entry_cnt_t         status2dma_free_entries,
  output cdma_status_pkg::entry_cnt_t         status2dma_wr_idx,
  output logic                                dp2reg_done,
  output cdma_status_pkg::done_intr_t         cdma_wt2glb_done_intr_pd,
  output cdma_status_pkg::done_intr_t         cdma_dat2glb_done_intr_pd
);

  import cdma_status_pkg::*;

  // merged fetch update and decoded engine levels
  buf_update_t dma_add;
  logic        wt_done;
  logic        dat_done;
  logic        dat_pend;

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  cdma_status_decode u_decode (
    .dc2status_dat    (dc2status_dat),
    .img2status_dat   (img2status_dat),
    .dc2status_state  (dc2status_state),
    .img2status_state (img2status_state),
    .wt2status_state  (wt2status_state),
    .dma_add          (dma_add),
    .wt_done          (wt_done),
    .dat_done         (dat_done),
    .dat_pend         (dat_pend)
  );

  ////////////////////////////////////////////////////////////
  // buffer accounting
  ////////////////////////////////////////////////////////////

  cbuf_accounting u_accounting (
    .nvdla_core_clk          (nvdla_core_clk),
    .rst                     (rst),
    .reg2dp_op_en            (reg2dp_op_en),
    .reg2dp_data_bank        (reg2dp_data_bank),
    .dma_add                 (dma_add),
    .sc2cdma_dat             (sc2cdma_dat),
    .dat_pend                (dat_pend),
    .sc2cdma_dat_pending_req (sc2cdma_dat_pending_req),
    .cdma2sc_dat_pending_ack (cdma2sc_dat_pending_ack),
    .status2dma_valid_slices (status2dma_valid_slices),
    .status2dma_free_entries (status2dma_free_entries),
    .status2dma_wr_idx       (status2dma_wr_idx)
  );

  ////////////////////////////////////////////////////////////
  // done and update results
  ////////////////////////////////////////////////////////////

  cdma_done_ctrl u_done (
    .nvdla_core_clk            (nvdla_core_clk),
    .rst                       (rst),
    .reg2dp_op_en              (reg2dp_op_en),
    .dp2reg_consumer           (dp2reg_consumer),
    .wt_done                   (wt_done),
    .dat_done                  (dat_done),
    .dp2reg_done               (dp2reg_done),
    .cdma_wt2glb_done_intr_pd  (cdma_wt2glb_done_intr_pd),
    .cdma_dat2glb_done_intr_pd (cdma_dat2glb_done_intr_pd)
  );

  // fetch updates reach the sequencer after a fixed delay
  cdma_update_delay u_delay (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .dma_add        (dma_add),
    .cdma2sc_dat    (cdma2sc_dat)
  );

endmodule

//--- rtl/cdma_status_decode.sv
`timescale 1ns/10ps

module cdma_status_decode (
  input  cdma_status_pkg::buf_update_t   dc2status_dat,
  input  cdma_status_pkg::buf_update_t   img2status_dat,
  input  cdma_status_pkg::status_state_e dc2status_state,
  input  cdma_status_pkg::status_state_e img2status_state,
  input  cdma_status_pkg::status_state_e wt2status_state,
  output cdma_status_pkg::buf_update_t   dma_add,
  output logic                           wt_done,
  output logic                           dat_done,
  output logic                           dat_pend
);

  import cdma_status_pkg::*;

  logic        dc_done;
  logic        dc_pend;
  logic        img_done;
  logic        img_pend;
  buf_update_t dc_masked;
  buf_update_t img_masked;

  ////////////////////////////////////////////////////////////
  // engine state decode
  ////////////////////////////////////////////////////////////

  assign wt_done  = (wt2status_state == STATE_DONE);
  assign dc_done  = (dc2status_state == STATE_DONE);
  assign dc_pend  = (dc2status_state == STATE_PEND);
  assign img_done = (img2status_state == STATE_DONE);
  assign img_pend = (img2status_state == STATE_PEND);

  // data side is done or pending when either image path is
  assign dat_done = dc_done | img_done;
  assign dat_pend = dc_pend | img_pend;

  ////////////////////////////////////////////////////////////
  // update merge
  ////////////////////////////////////////////////////////////

  // each record only counts while its own strobe is high
  assign dc_masked  = dc2status_dat & {$bits(buf_update_t){dc2status_dat.updt}};
  assign img_masked = img2status_dat & {$bits(buf_update_t){img2status_dat.updt}};

  // dc and img never update together, so an or is enough
  assign dma_add = dc_masked | img_masked;

endmodule

//--- rtl/cdma_status_pkg.sv
package cdma_status_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  // entry count width, covers the full convolution buffer
  localparam int ENTRY_W = 15;
  // slice count width
  localparam int SLICE_W = 14;
  // register bank field, holds enabled banks minus one
  localparam int BANK_W = 5;
  // 512 entries per bank
  localparam int BANK_DEPTH_BITS = 9;
  // stages between a fetch update and the sequencer
  localparam int STATUS_LATENCY = 6;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  // fetch engine state as seen by the status block
  typedef enum logic [1:0] {
    STATE_IDLE = 2'd0,
    STATE_PEND = 2'd1,
    STATE_RUN  = 2'd2,
    STATE_DONE = 2'd3
  } status_state_e;

  typedef logic [ENTRY_W-1:0] entry_cnt_t;
  typedef logic [SLICE_W-1:0] slice_cnt_t;
  // number of enabled banks, one bit wider than the field
  typedef logic [BANK_W:0] bank_num_t;

  // one buffer update, updt is a single-cycle strobe
  typedef struct packed {
    logic       updt;
    entry_cnt_t entries;
    slice_cnt_t slices;
  } buf_update_t;

  // bit 0 for consumer 0, bit 1 for consumer 1
  typedef logic [1:0] done_intr_t;

endpackage

//--- rtl/cdma_update_delay.sv
`timescale 1ns/10ps

module cdma_update_delay (
  input  logic                          nvdla_core_clk,
  input  logic                          rst,
  input  cdma_status_pkg::buf_update_t  dma_add,
  output cdma_status_pkg::buf_update_t  cdma2sc_dat
);

  import cdma_status_pkg::*;

  // stage 0 is one cycle after the fetch strobe
  buf_update_t stage [STATUS_LATENCY];

  ////////////////////////////////////////////////////////////
  // shift pipeline
  ////////////////////////////////////////////////////////////

  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      for (int i = 0; i < STATUS_LATENCY; i++) begin
        stage[i] <= '0;
      end
    end else begin
      // strobe moves every cycle
      stage[0].updt <= dma_add.updt;
      // payload only loads behind a strobe, otherwise holds
      if (dma_add.updt) begin
        stage[0].entries <= dma_add.entries;
        stage[0].slices  <= dma_add.slices;
      end
      for (int i = 1; i < STATUS_LATENCY; i++) begin
        stage[i].updt <= stage[i-1].updt;
        if (stage[i-1].updt) begin
          stage[i].entries <= stage[i-1].entries;
          stage[i].slices  <= stage[i-1].slices;
        end
      end
    end
  end

  // last stage lands STATUS_LATENCY cycles after the strobe
  assign cdma2sc_dat = stage[STATUS_LATENCY-1];

endmodule

//--- tests/tb_cdma_status_tasks.svh
////////////////////////////////////////////////////////////
// stimulus helpers
////////////////////////////////////////////////////////////

// lcg whose upper bits carry the better randomness
function automatic logic [31:0] next_rand();
  seed = seed * 32'd1103515245 + 32'd12345;
  return {8'd0, seed[31:8]};
endfunction

function automatic buf_update_t random_update();
  buf_update_t u;
  u.updt    = 1'b1;
  u.entries = entry_cnt_t'(next_rand() % 200 + 1);
  u.slices  = slice_cnt_t'(next_rand() % 40 + 1);
  return u;
endfunction

// only one fetch engine updates in a cycle
task automatic drive_fetch(input buf_update_t u, input logic use_img);
  dc2status_dat  = use_img ? buf_update_t'('0) : u;
  img2status_dat = use_img ? u : buf_update_t'('0);
endtask

task automatic add_to_model(input buf_update_t u);
  exp_entries = exp_entries + u.entries;
  exp_slices  = exp_slices + u.slices;
  exp_wr_idx  = exp_wr_idx + u.entries;
  // write index starts over past the last enabled bank
  if (exp_wr_idx >= BANK_CAP) begin
    exp_wr_idx = exp_wr_idx - BANK_CAP;
  end
endtask

////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////

task automatic tally(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
  end
endtask

task automatic check_update(input string name, input buf_update_t got, input buf_update_t exp);
  tally(name, 32'(got), 32'(exp));
endtask

task automatic check_entry(input string name, input entry_cnt_t got, input entry_cnt_t exp);
  tally(name, 32'(got), 32'(exp));
endtask

task automatic check_slice(input string name, input slice_cnt_t got, input slice_cnt_t exp);
  tally(name, 32'(got), 32'(exp));
endtask

task automatic check_intr(input string name, input done_intr_t got, input done_intr_t exp);
  tally(name, 32'(got), 32'(exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  tally(name, 32'(got), 32'(exp));
endtask

task automatic expect_counters();
  check_slice("status2dma_valid_slices", status2dma_valid_slices, slice_cnt_t'(exp_slices));
  check_entry("status2dma_free_entries", status2dma_free_entries,
              entry_cnt_t'(BANK_CAP - exp_entries));
  check_entry("status2dma_wr_idx", status2dma_wr_idx, entry_cnt_t'(exp_wr_idx));
endtask

// sends batch[0..n-1] one per cycle and watches each land 6 cycles later
task automatic stream_updates(input int n, input logic use_img);
  buf_update_t exp_out;
  for (int k = 0; k <= n + 6; k++) begin
    if (k >= 6 && k - 6 < n) begin
      exp_out  = batch[k-6];
      last_out = batch[k-6];
    end else begin
      // payload holds, only the strobe drops
      exp_out      = last_out;
      exp_out.updt = 1'b0;
    end
    check_update("cdma2sc_dat", cdma2sc_dat, exp_out);
    if (k < n) begin
      drive_fetch(batch[k], use_img);
      add_to_model(batch[k]);
    end else begin
      drive_fetch('0, use_img);
    end
    @(negedge nvdla_core_clk);
  end
  expect_counters();
endtask

task automatic apply_release(input entry_cnt_t e, input slice_cnt_t s);
  sc2cdma_dat = '{updt: 1'b1, entries: e, slices: s};
  exp_entries = exp_entries - e;
  exp_slices  = exp_slices - s;
  @(negedge nvdla_core_clk);
  sc2cdma_dat = '0;
  expect_counters();
endtask

////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////

task automatic after_reset_outputs();
  @(negedge nvdla_core_clk);
  check_update("cdma2sc_dat", cdma2sc_dat, '0);
  check_bit("cdma2sc_dat_pending_ack", cdma2sc_dat_pending_ack, 1'b0);
  check_slice("status2dma_valid_slices", status2dma_valid_slices, '0);
  check_entry("status2dma_free_entries", status2dma_free_entries, '0);
  check_entry("status2dma_wr_idx", status2dma_wr_idx, '0);
  check_bit("dp2reg_done", dp2reg_done, 1'b0);
  check_intr("cdma_wt2glb_done_intr_pd", cdma_wt2glb_done_intr_pd, '0);
  check_intr("cdma_dat2glb_done_intr_pd", cdma_dat2glb_done_intr_pd, '0);
endtask

task automatic fetch_updates();
  reg2dp_op_en     = 1'b1;
  reg2dp_data_bank = 5'd3;
  // bank count registers first, free entries follow a cycle later
  repeat (2) @(negedge nvdla_core_clk);
  expect_counters();
  batch[0] = random_update();
  stream_updates(1, 1'b0);
  for (int i = 0; i < 3; i++) begin
    batch[i] = random_update();
  end
  stream_updates(3, 1'b1);
endtask

task automatic sequencer_release();
  apply_release(entry_cnt_t'(exp_entries / 2), slice_cnt_t'(exp_slices / 2));
endtask

task automatic write_index_wrap();
  // empty the buffer, then fill to just short of the last bank
  apply_release(entry_cnt_t'(exp_entries), slice_cnt_t'(exp_slices));
  batch[0]         = random_update();
  batch[0].entries = entry_cnt_t'(BANK_CAP - 16 - exp_wr_idx);
  stream_updates(1, 1'b0);
  apply_release(entry_cnt_t'(exp_entries), slice_cnt_t'(exp_slices));
  // this one crosses the end and wraps
  batch[0]         = random_update();
  batch[0].entries = batch[0].entries + 16;
  stream_updates(1, 1'b1);
endtask

task automatic pending_clear();
  check_bit("cdma2sc_dat_pending_ack", cdma2sc_dat_pending_ack, 1'b0);
  dc2status_state = STATE_PEND;
  @(negedge nvdla_core_clk);
  check_bit("cdma2sc_dat_pending_ack", cdma2sc_dat_pending_ack, 1'b1);
  sc2cdma_dat_pending_req = 1'b1;
  // request copy lags a cycle, so nothing clears yet
  @(negedge nvdla_core_clk);
  expect_counters();
  exp_entries = 0;
  exp_slices  = 0;
  exp_wr_idx  = 0;
  @(negedge nvdla_core_clk);
  expect_counters();
  sc2cdma_dat_pending_req = 1'b0;
  dc2status_state         = STATE_IDLE;
  @(negedge nvdla_core_clk);
  check_bit("cdma2sc_dat_pending_ack", cdma2sc_dat_pending_ack, 1'b0);
endtask

task automatic done_interrupts();
  for (int c = 0; c < 2; c++) begin
    dp2reg_consumer = c[0];
    wt2status_state = STATE_DONE;
    @(negedge nvdla_core_clk);
    check_intr("cdma_wt2glb_done_intr_pd", cdma_wt2glb_done_intr_pd, done_intr_t'(1 << c));
    check_intr("cdma_dat2glb_done_intr_pd", cdma_dat2glb_done_intr_pd, '0);
    check_bit("dp2reg_done", dp2reg_done, 1'b0);
    dc2status_state = STATE_DONE;
    @(negedge nvdla_core_clk);
    // weight pulse is over, data pulse and layer done arrive together
    check_intr("cdma_wt2glb_done_intr_pd", cdma_wt2glb_done_intr_pd, '0);
    check_intr("cdma_dat2glb_done_intr_pd", cdma_dat2glb_done_intr_pd, done_intr_t'(1 << c));
    check_bit("dp2reg_done", dp2reg_done, 1'b1);
    wt2status_state = STATE_IDLE;
    dc2status_state = STATE_IDLE;
    @(negedge nvdla_core_clk);
    check_intr("cdma_wt2glb_done_intr_pd", cdma_wt2glb_done_intr_pd, '0);
    check_intr("cdma_dat2glb_done_intr_pd", cdma_dat2glb_done_intr_pd, '0);
    check_bit("dp2reg_done", dp2reg_done, 1'b0);
    @(negedge nvdla_core_clk);
  end
endtask

//--- tests/tb_cdma_status.sv
`timescale 1ns/10ps

module tb_cdma_status;

  import cdma_status_pkg::*;

  // the directed tests need under 100 cycles, so this leaves a wide margin
  localparam int MAX_CYCLES = 2000;
  // data_bank 3 enables four banks of 512 entries
  localparam int BANK_CAP = 2048;

  logic          nvdla_core_clk;
  logic          rst;
  buf_update_t   dc2status_dat;
  buf_update_t   img2status_dat;
  status_state_e dc2status_state;
  status_state_e img2status_state;
  status_state_e wt2status_state;
  buf_update_t   sc2cdma_dat;
  logic          sc2cdma_dat_pending_req;
  logic          reg2dp_op_en;
  logic          dp2reg_consumer;
  logic [BANK_W-1:0] reg2dp_data_bank;
  buf_update_t   cdma2sc_dat;
  logic          cdma2sc_dat_pending_ack;
  slice_cnt_t    status2dma_valid_slices;
  entry_cnt_t    status2dma_free_entries;
  entry_cnt_t    status2dma_wr_idx;
  logic          dp2reg_done;
  done_intr_t    cdma_wt2glb_done_intr_pd;
  done_intr_t    cdma_dat2glb_done_intr_pd;

  // reference model of the buffer in plain integers
  int unsigned exp_entries;
  int unsigned exp_slices;
  int unsigned exp_wr_idx;
  // last payload seen at the sequencer side and held between strobes
  buf_update_t last_out;
  buf_update_t batch [3];
  int unsigned checks;
  int unsigned errors;
  int unsigned cycles;
  logic [31:0] seed;

  `include "tb_cdma_status_tasks.svh"

  cdma_status uut (.*);

  initial nvdla_core_clk = 1'b0;
  always #2 nvdla_core_clk = ~nvdla_core_clk;

  // watchdog on the core clock
  always @(posedge nvdla_core_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed = 32'hc225;
    checks = 0;
    errors = 0;
    exp_entries = 0;
    exp_slices = 0;
    exp_wr_idx = 0;
    last_out = '0;
    rst = 1'b1;
    dc2status_dat = '0;
    img2status_dat = '0;
    sc2cdma_dat = '0;
    dc2status_state = STATE_IDLE;
    img2status_state = STATE_IDLE;
    wt2status_state = STATE_IDLE;
    sc2cdma_dat_pending_req = 1'b0;
    reg2dp_op_en = 1'b0;
    dp2reg_consumer = 1'b0;
    reg2dp_data_bank = '0;
    repeat (16) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    rst = 1'b0;
    after_reset_outputs();
    fetch_updates();
    sequencer_release();
    write_index_wrap();
    pending_clear();
    done_interrupts();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
